//--- mul8_macros.svh
`ifndef MUL8_MACROS_SVH
`define MUL8_MACROS_SVH

// The reduction tree is wired for exactly this operand width
`define MUL8_OPERAND_W 8

// Full product width
`define MUL8_PRODUCT_W 16

// Width of the two reduced rows and of the final adder
`define MUL8_ROW_W 14

// Clock stages from in_valid to out_valid
`define MUL8_LATENCY 3

`endif

//--- mul8_pkg.sv
`default_nettype none

`include "mul8_macros.svh"

package mul8_pkg;

    typedef struct packed {
        logic [`MUL8_OPERAND_W-1:0] a;
        logic [`MUL8_OPERAND_W-1:0] b;
    } operands_t;

    // Row i is b gated by bit i of a, so element [i][j] carries weight i+j
    typedef logic [`MUL8_OPERAND_W-1:0][`MUL8_OPERAND_W-1:0] pp_rows_t;

    // Bit k of each row carries weight k+1
    typedef struct packed {
        logic [`MUL8_ROW_W-1:0] row_a;
        logic [`MUL8_ROW_W-1:0] row_b;
        logic                   lsb;
    } sum_rows_t;

    typedef logic [`MUL8_PRODUCT_W-1:0] product_t;

endpackage

`default_nettype wire

//--- carry_lookahead_adder.sv
`timescale 1ns/1ps
`default_nettype none

module carry_lookahead_adder #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [WIDTH:0]   carry;

    assign gen      = in_a & in_b;
    assign prop     = in_a ^ in_b;
    assign carry[0] = cin;

    // Carry into bit i+1 is Gi + Pi*Ci
    for (genvar i = 0; i < WIDTH; i++) begin : g_carry
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end

    assign sum  = prop ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

`default_nettype wire

//--- partial_product_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul8_macros.svh"

module partial_product_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mul8_pkg::operands_t  operands,
    output logic                 pp_valid,
    output mul8_pkg::pp_rows_t   pp_rows
);

    mul8_pkg::pp_rows_t rows_next;

    always_comb begin
        for (int i = 0; i < `MUL8_OPERAND_W; i++) begin
            rows_next[i] = operands.a[i] ? operands.b : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pp_rows <= rows_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

//--- dadda_reduction_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dadda_reduction_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pp_valid,
    input  mul8_pkg::pp_rows_t   pp_rows,
    output logic                 rows_valid,
    output mul8_pkg::sum_rows_t  rows
);

    logic [3:0] s1, s2, s3, s4, s5, s6, s7, s8, s9, s10;
    logic [1:0] s11;
    logic       c1, c2, c3, c4, c5, c6, c7, c8, c9, c10, c11;
    mul8_pkg::sum_rows_t rows_next;

    // Bit 0 of each group operand sits in the group's lowest column, as does its carry-in

    // Stage 1 works on the raw dots of the densest columns
    carry_lookahead_adder #(.WIDTH(4)) i_cla_1 (
        .in_a({pp_rows[2][7], pp_rows[1][7], pp_rows[0][7], pp_rows[0][6]}),
        .in_b({pp_rows[3][6], pp_rows[2][6], pp_rows[1][6], pp_rows[1][5]}),
        .cin(pp_rows[2][4]), .sum(s1), .cout(c1));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_2 (
        .in_a({pp_rows[3][7], pp_rows[4][5], pp_rows[3][5], pp_rows[2][5]}),
        .in_b({pp_rows[4][6], pp_rows[5][4], pp_rows[4][4], pp_rows[3][4]}),
        .cin(pp_rows[4][3]), .sum(s2), .cout(c2));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_3 (
        .in_a({pp_rows[3][3], pp_rows[0][5], pp_rows[0][4], pp_rows[0][3]}),
        .in_b({pp_rows[4][2], pp_rows[1][4], pp_rows[1][3], pp_rows[1][2]}),
        .cin(pp_rows[2][1]), .sum(s3), .cout(c3));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_4 (
        .in_a({pp_rows[4][7], pp_rows[5][5], pp_rows[6][3], pp_rows[5][3]}),
        .in_b({pp_rows[5][6], pp_rows[6][4], pp_rows[7][2], pp_rows[6][2]}),
        .cin(pp_rows[7][1]), .sum(s4), .cout(c4));

    // Stage 2 mixes the leftover raw dots with stage 1 sums
    carry_lookahead_adder #(.WIDTH(4)) i_cla_5 (
        .in_a({pp_rows[5][2], pp_rows[5][1], pp_rows[2][3], pp_rows[2][2]}),
        .in_b({pp_rows[6][1], pp_rows[6][0], pp_rows[3][2], pp_rows[3][1]}),
        .cin(pp_rows[4][0]), .sum(s5), .cout(c5));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_6 (
        .in_a({s1[2], pp_rows[7][0], s1[0], pp_rows[4][1]}),
        .in_b({s2[1], s1[1], s3[3], pp_rows[5][0]}),
        .cin(s3[2]), .sum(s6), .cout(c6));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_7 (
        .in_a({pp_rows[6][7], pp_rows[5][7], pp_rows[6][5], pp_rows[7][3]}),
        .in_b({pp_rows[7][6], pp_rows[6][6], pp_rows[7][4], c1}),
        .cin(s2[3]), .sum(s7), .cout(c7));

    // Stage 3 chains through its own carries in the middle columns
    carry_lookahead_adder #(.WIDTH(4)) i_cla_8 (
        .in_a({pp_rows[7][5], c2, s4[2], s1[3]}),
        .in_b({c4, s4[3], s7[0], s2[2]}),
        .cin(s4[1]), .sum(s8), .cout(c8));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_9 (
        .in_a({s5[1], s3[1], pp_rows[3][0], pp_rows[0][2]}),
        .in_b({s6[0], s5[0], s3[0], pp_rows[1][1]}),
        .cin(pp_rows[2][0]), .sum(s9), .cout(c9));
    carry_lookahead_adder #(.WIDTH(4)) i_cla_10 (
        .in_a({c6, s4[0], s2[0], s5[2]}),
        .in_b({s8[0], c5, c3, s6[1]}),
        .cin(c9), .sum(s10), .cout(c10));
    carry_lookahead_adder #(.WIDTH(2)) i_cla_11 (
        .in_a({s6[3], s5[3]}),
        .in_b({s10[2], s6[2]}),
        .cin(s10[1]), .sum(s11), .cout(c11));

    // Columns 2 to 8 end with a single dot, so row_b is zero there
    always_comb begin
        rows_next.lsb   = pp_rows[0][0];
        rows_next.row_a = {pp_rows[7][7], c8, s8[3:1], s10[3], s11,
                           s10[0], s9, pp_rows[0][1]};
        rows_next.row_b = {c7, s7[3:1], c10, c11, 7'd0, pp_rows[1][0]};
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            rows <= rows_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rows_valid <= 1'b0;
        end else begin
            rows_valid <= pp_valid;
        end
    end

endmodule

`default_nettype wire

//--- final_add_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul8_macros.svh"

module final_add_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rows_valid,
    input  mul8_pkg::sum_rows_t  rows,
    output logic                 out_valid,
    output mul8_pkg::product_t   product
);

    logic [`MUL8_ROW_W-1:0] row_sum;
    logic                   row_cout;

    // The second column 1 dot enters through the carry-in
    carry_lookahead_adder #(.WIDTH(`MUL8_ROW_W)) i_cla_final (
        .in_a(rows.row_a),
        .in_b({rows.row_b[`MUL8_ROW_W-1:1], 1'b0}),
        .cin(rows.row_b[0]),
        .sum(row_sum),
        .cout(row_cout)
    );

    always_ff @(posedge clk) begin
        if (rows_valid) begin
            product <= {row_cout, row_sum, rows.lsb};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rows_valid;
        end
    end

endmodule

`default_nettype wire

//--- mul8_top.sv
`timescale 1ns/1ps
`default_nettype none

module mul8_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mul8_pkg::operands_t  operands,
    output logic                 out_valid,
    output mul8_pkg::product_t   product
);

    logic                pp_valid;
    mul8_pkg::pp_rows_t  pp_rows;
    logic                rows_valid;
    mul8_pkg::sum_rows_t rows;

    partial_product_stage i_pp_stage (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .operands(operands),
        .pp_valid(pp_valid),
        .pp_rows(pp_rows)
    );

    dadda_reduction_stage i_reduce_stage (
        .clk(clk),
        .reset(reset),
        .pp_valid(pp_valid),
        .pp_rows(pp_rows),
        .rows_valid(rows_valid),
        .rows(rows)
    );

    final_add_stage i_add_stage (
        .clk(clk),
        .reset(reset),
        .rows_valid(rows_valid),
        .rows(rows),
        .out_valid(out_valid),
        .product(product)
    );

endmodule

`default_nettype wire

//--- mul8_top_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul8_macros.svh"

module mul8_top_props (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mul8_pkg::operands_t  operands,
    input  logic                 pp_valid,
    input  logic                 rows_valid,
    input  logic                 out_valid,
    input  mul8_pkg::product_t   product
);

    // A strobe survives only if no reset hit any of the three stage registers
    a_valid_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid == ($past(in_valid && !reset, `MUL8_LATENCY)
                      && !$past(reset, 2) && !$past(reset, 1)))
        else $error("out_valid does not follow in_valid by the pipeline latency");

    a_reset_clears: assert property (@(posedge clk)
        reset |=> (!pp_valid && !rows_valid && !out_valid))
        else $error("A valid strobe is still high in the cycle after reset");

    a_product_value: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> product ==
            mul8_pkg::product_t'($past(operands.a, `MUL8_LATENCY))
            * mul8_pkg::product_t'($past(operands.b, `MUL8_LATENCY)))
        else $error("product differs from the operands accepted three cycles earlier");

endmodule

bind mul8_top mul8_top_props i_props (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .operands(operands),
    .pp_valid(pp_valid),
    .rows_valid(rows_valid),
    .out_valid(out_valid),
    .product(product)
);

`default_nettype wire

//--- tb_mul8_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul8_macros.svh"

module tb_mul8_top;

    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        mul8_pkg::product_t product;
        logic [31:0]        sent_edge;
    } pending_t;

    logic                clk;
    logic                reset;
    logic                in_valid;
    mul8_pkg::operands_t operands;
    logic                out_valid;
    mul8_pkg::product_t  product;

    logic [31:0] edge_count = '0;
    pending_t    pending[$];
    int          mismatch_count = 0;
    int          other_errors = 0;
    logic        burst = 1'b1;

    mul8_top i_dut (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .operands(operands),
        .out_valid(out_valid),
        .product(product)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 32'd1;
    end

    task automatic check_product(input mul8_pkg::product_t expected,
                                 input mul8_pkg::product_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch product: expected 0x%h, got 0x%h at edge %0d",
                     expected, actual, edge_count);
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch out_valid: expected 0x%h, got 0x%h at edge %0d",
                     expected, actual, edge_count);
        end
    endtask

    // The scoreboard compares each cycle's outputs with the head of the queue
    always @(negedge clk) begin : monitor
        logic     exp_valid;
        pending_t head;
        if (!reset) begin
            exp_valid = (pending.size() > 0)
                        && (pending[0].sent_edge + `MUL8_LATENCY == edge_count);
            if (out_valid === 1'b1 && pending.size() == 0) begin
                other_errors++;
                $display("Unexpected out_valid at edge %0d with no product pending", edge_count);
            end else begin
                check_valid(exp_valid, out_valid);
            end
            if (exp_valid) begin
                head = pending.pop_front();
                if (out_valid === 1'b1) begin
                    check_product(head.product, product);
                end
            end
        end
    end

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic send_entry(input logic [7:0] a_val, input logic [7:0] b_val,
                              input mul8_pkg::product_t exp_val);
        pending_t entry;
        if (mul8_pkg::product_t'(a_val) * mul8_pkg::product_t'(b_val) != exp_val) begin
            other_errors++;
            $display("Stimulus entry %h times %h lists a wrong product %h", a_val, b_val, exp_val);
        end
        @(posedge clk);
        #1;
        in_valid        = 1'b1;
        operands.a      = a_val;
        operands.b      = b_val;
        entry.product   = exp_val;
        entry.sent_edge = edge_count;
        pending.push_back(entry);
    endtask

    // Products still in the pipeline are lost, so their entries go too
    task automatic pulse_reset();
        @(posedge clk);
        #1;
        reset    = 1'b1;
        in_valid = 1'b0;
        pending.delete();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_idle(3);
    endtask

    task automatic run_stimulus(input int fd);
        string              line;
        int                 fields;
        logic [7:0]         a_val;
        logic [7:0]         b_val;
        mul8_pkg::product_t exp_val;
        while ($fgets(line, fd) != 0) begin
            if (line.len() <= 1 || line.substr(0, 0) == "#") begin
                continue;
            end
            if (line.substr(0, 0) == "R") begin
                pulse_reset();
                burst = !burst;
                continue;
            end
            fields = $sscanf(line, "%h %h %h", a_val, b_val, exp_val);
            if (fields != 3) begin
                other_errors++;
                $display("Stimulus line could not be read: %s", line);
            end else begin
                send_entry(a_val, b_val, exp_val);
                if (!burst) begin
                    drive_idle(int'($urandom % 3));
                end
            end
        end
        $fclose(fd);
        drive_idle(1);
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (pending.size() > 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pending.size() > 0) begin
            other_errors++;
            $display("Timeout: %0d products still pending after %0d cycles",
                     pending.size(), DRAIN_LIMIT);
        end
    endtask

    task automatic finish_run();
        $display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        int fd;
        void'($urandom(32'he568));
        reset    = 1'b1;
        in_valid = 1'b0;
        operands = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("mul8_stim.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file mul8_stim.txt");
        end else begin
            run_stimulus(fd);
            wait_for_drain();
            // A few idle cycles to catch a stray out_valid after the last product
            drive_idle(4);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- mul8_top.f
+incdir+.
mul8_pkg.sv
carry_lookahead_adder.sv
partial_product_stage.sv
dadda_reduction_stage.sv
final_add_stage.sv
mul8_top.sv
mul8_top_props.sv
tb_mul8_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mul8_top -f mul8_top.f &&
./obj_dir/Vtb_mul8_top | tee /dev/stderr | grep -qx "Done: no errors" ||
{ echo "Simulation failed"; exit 1; }

//--- mul8_stim.txt
# Columns: a b expected_product, all hex; a line holding only R pulses reset
# Entries start back-to-back, and each R toggles between random gaps and back-to-back
00 00 0000
01 01 0001
ff ff fe01
01 ff 00ff
ff 01 00ff
80 ff 7f80
ff 80 7f80
02 04 0008
10 10 0100
80 80 4000
07 09 003f
09 07 003f
03 05 000f
R
0f 0f 00e1
a5 5a 3a02
7f 7f 3f01
ff 00 0000
00 ff 0000
c3 3c 2db4
12 34 03a8
fe ff fd02
40 02 0080
07 09 003f
R
ab cd 88ef
55 aa 3872
ff fe fd02
01 80 0080
e7 9b 8bdd
33 33 0a29
f0 0f 0e10
04 40 0100
ff ff fe01
